//--- logic/udp_pkg.sv
package udp_pkg;

    // ******************************
    // frame constants
    // ******************************
    localparam logic [7:0]  PREAMBLE_BYTE     = 8'h55;         // sent seven times
    localparam logic [7:0]  SFD_BYTE          = 8'hd5;
    localparam logic [15:0] ETH_TYPE_IPV4     = 16'h0800;
    localparam logic [7:0]  IP_VER_IHL        = 8'h45;         // ipv4, five header words
    localparam logic [15:0] IP_FLAGS_DF       = 16'h4000;      // don't fragment, offset 0
    localparam logic [7:0]  IP_TTL            = 8'd64;
    localparam logic [7:0]  IP_PROTO_UDP      = 8'd17;
    localparam logic [15:0] IP_UDP_HDR_BYTES  = 16'd28;
    localparam logic [15:0] UDP_HDR_BYTES     = 16'd8;

    // 46 byte ethernet minimum less the ip and udp headers
    localparam logic [15:0] MIN_PAYLOAD_BYTES = 16'd18;

    localparam logic [31:0] CRC32_POLY_REFL   = 32'hedb8_8320;

    // ******************************
    // configuration register map
    // ******************************
    localparam int CFG_ADDR_W = 3;

    localparam logic [CFG_ADDR_W-1:0] CFG_SRC_MAC_HI = 3'd0;
    localparam logic [CFG_ADDR_W-1:0] CFG_SRC_MAC_LO = 3'd1;
    localparam logic [CFG_ADDR_W-1:0] CFG_DST_MAC_HI = 3'd2;
    localparam logic [CFG_ADDR_W-1:0] CFG_DST_MAC_LO = 3'd3;
    localparam logic [CFG_ADDR_W-1:0] CFG_SRC_IP     = 3'd4;
    localparam logic [CFG_ADDR_W-1:0] CFG_DST_IP     = 3'd5;
    localparam logic [CFG_ADDR_W-1:0] CFG_PORTS      = 3'd6;   // src port high, dst port low

endpackage

//--- logic/udp_cfg_regs.sv
`timescale 1ns/1ps

module udp_cfg_regs #(
    parameter logic [47:0] BOARD_MAC = 48'h00_0a_35_01_fe_c0,
    parameter logic [47:0] DES_MAC   = 48'hff_ff_ff_ff_ff_ff,
    parameter logic [31:0] BOARD_IP  = {8'd192, 8'd168, 8'd1, 8'd10},
    parameter logic [31:0] DES_IP    = {8'd192, 8'd168, 8'd1, 8'd102},
    parameter logic [15:0] SRC_PORT  = 16'd1234,
    parameter logic [15:0] DST_PORT  = 16'd1234
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           cfg_wr,
    input  logic [udp_pkg::CFG_ADDR_W-1:0] cfg_addr,
    input  logic [31:0]                    cfg_wdata,
    output logic [47:0]                    src_mac,
    output logic [47:0]                    dst_mac,
    output logic [31:0]                    src_ip,
    output logic [31:0]                    dst_ip,
    output logic [15:0]                    src_port,
    output logic [15:0]                    dst_port
);

    // ******************************
    // address and port registers
    // ******************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            src_mac  <= BOARD_MAC;
            dst_mac  <= DES_MAC;
            src_ip   <= BOARD_IP;
            dst_ip   <= DES_IP;
            src_port <= SRC_PORT;
            dst_port <= DST_PORT;
        end else if (cfg_wr) begin
            // mac writes touch only the addressed half
            case (cfg_addr)
                udp_pkg::CFG_SRC_MAC_HI: src_mac[47:32] <= cfg_wdata[15:0];
                udp_pkg::CFG_SRC_MAC_LO: src_mac[31:0]  <= cfg_wdata;
                udp_pkg::CFG_DST_MAC_HI: dst_mac[47:32] <= cfg_wdata[15:0];
                udp_pkg::CFG_DST_MAC_LO: dst_mac[31:0]  <= cfg_wdata;
                udp_pkg::CFG_SRC_IP:     src_ip         <= cfg_wdata;
                udp_pkg::CFG_DST_IP:     dst_ip         <= cfg_wdata;
                udp_pkg::CFG_PORTS: begin
                    src_port <= cfg_wdata[31:16];
                    dst_port <= cfg_wdata[15:0];
                end
                default: ;  // address 7 is unmapped
            endcase
        end
    end

endmodule

//--- logic/payload_fifo.sv
`timescale 1ns/1ps

module payload_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        wr_en,
    input  logic [31:0] wr_data,
    input  logic        rd_en,
    output logic [31:0] rd_data,
    output logic        full,
    output logic        empty
);

    localparam int          AW         = $clog2(FIFO_DEPTH);
    localparam logic [AW:0] FULL_COUNT = FIFO_DEPTH[AW:0];

    logic [31:0]   mem [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;          // wraps on its own, depth is a power of two
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          do_wr;
    logic          do_rd;

    assign full  = (count == FULL_COUNT);
    assign empty = (count == '0);
    assign do_wr = wr_en && !full;  // write into a full buffer is lost
    assign do_rd = rd_en && !empty;

    always_ff @(posedge clk) begin
        if (do_wr)
            mem[wr_ptr] <= wr_data;
        if (do_rd)
            rd_data <= mem[rd_ptr]; // one cycle read latency
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

endmodule

//--- logic/eth_crc32_d8.sv
`timescale 1ns/1ps

module eth_crc32_d8 (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        crc_en,
    input  logic        crc_clr,
    input  logic [7:0]  data_in,
    output logic [31:0] crc_data,
    output logic [7:0]  crc_next
);

    logic [31:0] crc_upd;

    // reflected crc-32, one byte lsb first
    function automatic logic [31:0] crc_step(input logic [31:0] crc, input logic [7:0] din);
        logic [31:0] c;
        int          i;
        c = crc ^ {24'h0, din};
        for (i = 0; i < 8; i++) begin
            if (c[0])
                c = (c >> 1) ^ udp_pkg::CRC32_POLY_REFL;
            else
                c = c >> 1;
        end
        return c;
    endfunction

    assign crc_upd  = crc_step(crc_data, data_in);
    assign crc_next = crc_upd[7:0];     // lets the framer send fcs byte 0 with no gap

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crc_data <= '1;
        end else if (crc_clr) begin
            crc_data <= '1;             // ready for the next frame
        end else if (crc_en) begin
            crc_data <= crc_upd;
        end
    end

endmodule

//--- logic/udp_tx.sv
`timescale 1ns/1ps

module udp_tx (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        tx_start,
    input  logic [15:0] tx_byte_num,
    input  logic [47:0] src_mac,
    input  logic [47:0] dst_mac,
    input  logic [31:0] src_ip,
    input  logic [31:0] dst_ip,
    input  logic [15:0] src_port,
    input  logic [15:0] dst_port,
    input  logic [31:0] tx_data,
    input  logic [31:0] crc_data,
    input  logic [7:0]  crc_next,
    output logic        tx_req,
    output logic        gmii_tx_en,
    output logic [7:0]  gmii_txd,
    output logic        crc_en,
    output logic        crc_clr,
    output logic        tx_done,
    output logic        tx_busy
);

    // one-hot sequencer states
    localparam logic [6:0] S_IDLE = 7'b000_0001;
    localparam logic [6:0] S_CSUM = 7'b000_0010;
    localparam logic [6:0] S_PRE  = 7'b000_0100;
    localparam logic [6:0] S_ETH  = 7'b000_1000;
    localparam logic [6:0] S_IPH  = 7'b001_0000;
    localparam logic [6:0] S_DATA = 7'b010_0000;
    localparam logic [6:0] S_CRC  = 7'b100_0000;

    logic [6:0]   state;
    logic [4:0]   cnt;          // byte or step index within a state
    logic [15:0]  data_cnt;
    logic [15:0]  byte_num;     // user byte count of this frame
    logic [15:0]  pad_num;      // byte count after padding
    logic [15:0]  ip_id;
    logic [31:0]  csum;
    logic [111:0] eth_hdr;      // dst mac, src mac, ethertype
    logic [31:0]  ip_hdr [7];   // five ip words then two udp words
    logic [31:0]  ip_word;
    logic [7:0]   eth_byte;
    logic [7:0]   ip_byte;
    logic [7:0]   data_byte;

    assign tx_busy   = (state != S_IDLE) || tx_start;
    assign ip_word   = ip_hdr[cnt[4:2]];
    assign eth_byte  = eth_hdr[8*(13-cnt) +: 8];
    assign ip_byte   = ip_word[8*(3-cnt[1:0]) +: 8];
    assign data_byte = tx_data[8*(3-data_cnt[1:0]) +: 8];   // msb first

    // ******************************
    // header words and checksum
    // ******************************
    always_ff @(posedge clk) begin
        if (state == S_IDLE && tx_start) begin
            eth_hdr   <= {dst_mac, src_mac, udp_pkg::ETH_TYPE_IPV4};
            ip_hdr[0] <= {udp_pkg::IP_VER_IHL, 8'h00, tx_byte_num + udp_pkg::IP_UDP_HDR_BYTES};
            ip_hdr[1] <= {ip_id + 16'd1, udp_pkg::IP_FLAGS_DF};
            ip_hdr[2] <= {udp_pkg::IP_TTL, udp_pkg::IP_PROTO_UDP, 16'h0000};
            ip_hdr[3] <= src_ip;
            ip_hdr[4] <= dst_ip;
            ip_hdr[5] <= {src_port, dst_port};
            ip_hdr[6] <= {tx_byte_num + udp_pkg::UDP_HDR_BYTES, 16'h0000};  // no udp checksum
        end
        if (state == S_CSUM) begin
            case (cnt)
                5'd0: csum <= ip_hdr[0][31:16] + ip_hdr[0][15:0] + ip_hdr[1][31:16]
                              + ip_hdr[1][15:0] + ip_hdr[2][31:16] + ip_hdr[2][15:0]
                              + ip_hdr[3][31:16] + ip_hdr[3][15:0] + ip_hdr[4][31:16]
                              + ip_hdr[4][15:0];
                5'd1, 5'd2: csum <= {16'h0, csum[31:16]} + {16'h0, csum[15:0]};  // fold carries
                default: ip_hdr[2][15:0] <= ~csum[15:0];
            endcase
        end
    end

    // ******************************
    // frame sequencer
    // ******************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= S_IDLE;
            cnt        <= '0;
            data_cnt   <= '0;
            byte_num   <= '0;
            pad_num    <= '0;
            ip_id      <= '0;
            tx_req     <= 1'b0;
            gmii_tx_en <= 1'b0;
            gmii_txd   <= '0;
            crc_en     <= 1'b0;
            crc_clr    <= 1'b0;
            tx_done    <= 1'b0;
        end else begin
            tx_req     <= 1'b0;
            gmii_tx_en <= 1'b0;
            crc_en     <= 1'b0;
            crc_clr    <= 1'b0;
            tx_done    <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (tx_start) begin
                        byte_num <= tx_byte_num;
                        pad_num  <= (tx_byte_num < udp_pkg::MIN_PAYLOAD_BYTES) ?
                                    udp_pkg::MIN_PAYLOAD_BYTES : tx_byte_num;
                        ip_id    <= ip_id + 16'd1;
                        cnt      <= '0;
                        state    <= S_CSUM;
                    end
                end
                S_CSUM: begin
                    cnt <= cnt + 5'd1;
                    if (cnt == 5'd3) begin
                        // first preamble byte goes out with the inverted sum
                        gmii_tx_en <= 1'b1;
                        gmii_txd   <= udp_pkg::PREAMBLE_BYTE;
                        cnt        <= 5'd1;
                        state      <= S_PRE;
                    end
                end
                S_PRE: begin
                    gmii_tx_en <= 1'b1;
                    if (cnt == 5'd7) begin
                        gmii_txd <= udp_pkg::SFD_BYTE;
                        cnt      <= '0;
                        state    <= S_ETH;
                    end else begin
                        gmii_txd <= udp_pkg::PREAMBLE_BYTE;
                        cnt      <= cnt + 5'd1;
                    end
                end
                S_ETH: begin
                    gmii_tx_en <= 1'b1;
                    crc_en     <= 1'b1;
                    gmii_txd   <= eth_byte;
                    cnt        <= cnt + 5'd1;
                    if (cnt == 5'd13) begin
                        cnt   <= '0;
                        state <= S_IPH;
                    end
                end
                S_IPH: begin
                    gmii_tx_en <= 1'b1;
                    crc_en     <= 1'b1;
                    gmii_txd   <= ip_byte;
                    cnt        <= cnt + 5'd1;
                    if (cnt == 5'd26 && byte_num != 16'd0)
                        tx_req <= 1'b1;     // first word, two byte slots ahead
                    if (cnt == 5'd27) begin
                        cnt      <= '0;
                        data_cnt <= '0;
                        state    <= S_DATA;
                    end
                end
                S_DATA: begin
                    gmii_tx_en <= 1'b1;
                    crc_en     <= 1'b1;
                    gmii_txd   <= (data_cnt < byte_num) ? data_byte : 8'h00;  // zero pad
                    // fetch the next word only if it holds real bytes
                    if (data_cnt[1:0] == 2'd2 && ({1'b0, data_cnt} + 17'd2) < {1'b0, byte_num})
                        tx_req <= 1'b1;
                    if (data_cnt == pad_num - 16'd1) begin
                        data_cnt <= '0;
                        cnt      <= '0;
                        state    <= S_CRC;
                    end else begin
                        data_cnt <= data_cnt + 16'd1;
                    end
                end
                S_CRC: begin
                    cnt <= cnt + 5'd1;
                    case (cnt)
                        5'd0: begin
                            gmii_tx_en <= 1'b1;
                            gmii_txd   <= ~crc_next;        // last data byte still folding
                        end
                        5'd1: begin
                            gmii_tx_en <= 1'b1;
                            gmii_txd   <= ~crc_data[15:8];
                        end
                        5'd2: begin
                            gmii_tx_en <= 1'b1;
                            gmii_txd   <= ~crc_data[23:16];
                        end
                        5'd3: begin
                            gmii_tx_en <= 1'b1;
                            gmii_txd   <= ~crc_data[31:24];
                        end
                        5'd4: begin
                            tx_done <= 1'b1;
                            crc_clr <= 1'b1;
                        end
                        default: begin
                            cnt   <= '0;
                            state <= S_IDLE;    // busy held through the done cycle
                        end
                    endcase
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

//--- logic/udp_tx_top.sv
`timescale 1ns/1ps

module udp_tx_top #(
    parameter logic [47:0] BOARD_MAC  = 48'h00_0a_35_01_fe_c0,
    parameter logic [47:0] DES_MAC    = 48'hff_ff_ff_ff_ff_ff,
    parameter logic [31:0] BOARD_IP   = {8'd192, 8'd168, 8'd1, 8'd10},
    parameter logic [31:0] DES_IP     = {8'd192, 8'd168, 8'd1, 8'd102},
    parameter logic [15:0] SRC_PORT   = 16'd1234,
    parameter logic [15:0] DST_PORT   = 16'd1234,
    parameter int          FIFO_DEPTH = 16
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           cfg_wr,
    input  logic [udp_pkg::CFG_ADDR_W-1:0] cfg_addr,
    input  logic [31:0]                    cfg_wdata,
    input  logic                           pl_wr,
    input  logic [31:0]                    pl_wdata,
    input  logic                           tx_start,
    input  logic [15:0]                    tx_byte_num,
    output logic                           gmii_tx_en,
    output logic [7:0]                     gmii_txd,
    output logic                           tx_done,
    output logic                           tx_busy,
    output logic                           pl_full
);

    logic [47:0] src_mac;
    logic [47:0] dst_mac;
    logic [31:0] src_ip;
    logic [31:0] dst_ip;
    logic [15:0] src_port;
    logic [15:0] dst_port;
    logic        tx_req;
    logic [31:0] tx_data;
    logic        pl_empty;      // watched by the bound checks
    logic        crc_en;
    logic        crc_clr;
    logic [31:0] crc_data;
    logic [7:0]  crc_next;

    udp_cfg_regs #(
        .BOARD_MAC(BOARD_MAC), .DES_MAC(DES_MAC), .BOARD_IP(BOARD_IP),
        .DES_IP(DES_IP), .SRC_PORT(SRC_PORT), .DST_PORT(DST_PORT)
    ) cfg_i (
        .clk, .rst_n, .cfg_wr, .cfg_addr, .cfg_wdata,
        .src_mac, .dst_mac, .src_ip, .dst_ip, .src_port, .dst_port
    );

    payload_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo_i (
        .clk, .rst_n, .wr_en(pl_wr), .wr_data(pl_wdata), .rd_en(tx_req),
        .rd_data(tx_data), .full(pl_full), .empty(pl_empty)
    );

    // crc folds the byte on the gmii output register
    eth_crc32_d8 crc_i (
        .clk, .rst_n, .crc_en, .crc_clr, .data_in(gmii_txd), .crc_data, .crc_next
    );

    udp_tx tx_i (
        .clk, .rst_n, .tx_start, .tx_byte_num, .src_mac, .dst_mac, .src_ip, .dst_ip,
        .src_port, .dst_port, .tx_data, .crc_data, .crc_next, .tx_req, .gmii_tx_en,
        .gmii_txd, .crc_en, .crc_clr, .tx_done, .tx_busy
    );

endmodule

//--- verif/udp_tx_asserts.sv
`timescale 1ns/1ps

module udp_tx_asserts (
    input logic clk,
    input logic rst_n,
    input logic tx_done,
    input logic gmii_tx_en,
    input logic tx_busy,
    input logic tx_req,
    input logic pl_empty
);

    // done is a single cycle pulse
    done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        tx_done |=> !tx_done)
        else $error("tx_done held high for more than one cycle");

    en_low_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !gmii_tx_en)
        else $error("gmii_tx_en high right after reset release");

    // not busy means the sequencer sits in idle
    en_low_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !tx_busy |-> !gmii_tx_en)
        else $error("gmii_tx_en high while the framer is idle");

    no_read_when_empty: assert property (@(posedge clk) disable iff (!rst_n)
        tx_req |-> !pl_empty)
        else $error("payload read requested from an empty buffer");

endmodule

bind udp_tx_top udp_tx_asserts asserts_i (
    .clk(clk), .rst_n(rst_n), .tx_done(tx_done), .gmii_tx_en(gmii_tx_en),
    .tx_busy(tx_busy), .tx_req(tx_req), .pl_empty(pl_empty)
);

//--- verif/udp_tx_tb.sv
`timescale 1ns/1ps

module udp_tx_tb;

    localparam int          CLK_PERIOD   = 100;
    localparam logic [47:0] BOARD_MAC    = 48'h02_1a_2b_3c_4d_5e;
    localparam logic [47:0] DES_MAC      = 48'h00_11_22_33_44_55;
    localparam logic [31:0] BOARD_IP     = 32'hc0a8_010a;
    localparam logic [31:0] DES_IP       = 32'hc0a8_0166;
    localparam logic [15:0] SRC_PORT     = 16'd1234;
    localparam logic [15:0] DST_PORT     = 16'd4321;
    localparam int          FIFO_DEPTH   = 16;
    localparam int          NUM_FRAMES   = 34;
    localparam int          FRAME_CYCLES = 150;    // longest frame plus load and gaps
    localparam int          WATCHDOG_CYCLES = 2 * (NUM_FRAMES * FRAME_CYCLES + 100);

    typedef logic [7:0] byte_q_t[$];

    logic        clk;
    logic        rst_n;
    logic        cfg_wr;
    logic [2:0]  cfg_addr;
    logic [31:0] cfg_wdata;
    logic        pl_wr;
    logic [31:0] pl_wdata;
    logic        tx_start;
    logic [15:0] tx_byte_num;
    logic        gmii_tx_en;
    logic [7:0]  gmii_txd;
    logic        tx_done;
    logic        tx_busy;
    logic        pl_full;

    // configuration mirror and frame bookkeeping
    logic [47:0] src_mac_m = BOARD_MAC;
    logic [47:0] dst_mac_m = DES_MAC;
    logic [31:0] src_ip_m  = BOARD_IP;
    logic [31:0] dst_ip_m  = DES_IP;
    logic [15:0] sport_m   = SRC_PORT;
    logic [15:0] dport_m   = DST_PORT;
    logic [15:0] exp_id    = '0;
    logic [7:0]  pl_bytes[$];
    logic [7:0]  exp_q[$];
    int          len_q[$];
    int          frames_sent = 0;
    int          frames_done = 0;

    udp_tx_top #(
        .BOARD_MAC(BOARD_MAC), .DES_MAC(DES_MAC), .BOARD_IP(BOARD_IP), .DES_IP(DES_IP),
        .SRC_PORT(SRC_PORT), .DST_PORT(DST_PORT), .FIFO_DEPTH(FIFO_DEPTH)
    ) dut_i (
        .clk, .rst_n, .cfg_wr, .cfg_addr, .cfg_wdata, .pl_wr, .pl_wdata, .tx_start,
        .tx_byte_num, .gmii_tx_en, .gmii_txd, .tx_done, .tx_busy, .pl_full
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ******************************
    // reporting
    // ******************************
    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
            fail_run($sformatf("** Error at %0t: %s = 0x%0h, expected 0x%0h",
                               $time, name, got, exp));
    endtask

    // ******************************
    // reference frame
    // ******************************
    function automatic byte_q_t build_frame(input int n, input logic [15:0] id,
                                            input logic [7:0] pl[$]);
        byte_q_t     body;
        byte_q_t     frame;
        logic [31:0] sum;
        logic [31:0] crc;
        logic [15:0] ip_len;
        logic [15:0] udp_len;
        int          i;
        int          b;
        int          plen;
        ip_len  = 16'(n + 28);
        udp_len = 16'(n + 8);
        plen    = (n < 18) ? 18 : n;
        for (i = 5; i >= 0; i--)
            body.push_back(dst_mac_m[8*i +: 8]);
        for (i = 5; i >= 0; i--)
            body.push_back(src_mac_m[8*i +: 8]);
        body.push_back(8'h08);
        body.push_back(8'h00);
        body.push_back(8'h45);
        body.push_back(8'h00);
        body.push_back(ip_len[15:8]);
        body.push_back(ip_len[7:0]);
        body.push_back(id[15:8]);
        body.push_back(id[7:0]);
        body.push_back(8'h40);      // don't fragment
        body.push_back(8'h00);
        body.push_back(8'd64);
        body.push_back(8'd17);
        body.push_back(8'h00);      // checksum filled in below
        body.push_back(8'h00);
        for (i = 3; i >= 0; i--)
            body.push_back(src_ip_m[8*i +: 8]);
        for (i = 3; i >= 0; i--)
            body.push_back(dst_ip_m[8*i +: 8]);
        body.push_back(sport_m[15:8]);
        body.push_back(sport_m[7:0]);
        body.push_back(dport_m[15:8]);
        body.push_back(dport_m[7:0]);
        body.push_back(udp_len[15:8]);
        body.push_back(udp_len[7:0]);
        body.push_back(8'h00);
        body.push_back(8'h00);
        for (i = 0; i < plen; i++)
            body.push_back((i < n) ? pl[i] : 8'h00);
        // ones complement sum over the 20 byte ip header
        sum = '0;
        for (i = 14; i < 34; i += 2)
            sum = sum + {16'h0, body[i], body[i+1]};
        while (sum[31:16] != 16'h0)
            sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
        body[24] = ~sum[15:8];
        body[25] = ~sum[7:0];
        crc = 32'hffff_ffff;
        foreach (body[i]) begin
            for (b = 0; b < 8; b++) begin
                if (crc[0] ^ body[i][b])
                    crc = (crc >> 1) ^ 32'hedb8_8320;
                else
                    crc = crc >> 1;
            end
        end
        for (i = 0; i < 7; i++)
            frame.push_back(8'h55);
        frame.push_back(8'hd5);
        foreach (body[i])
            frame.push_back(body[i]);
        for (i = 0; i < 4; i++)
            frame.push_back(~crc[8*i +: 8]);    // fcs low byte first
        return frame;
    endfunction

    // ******************************
    // stimulus tasks
    // ******************************
    task automatic write_cfg(input logic [2:0] addr, input logic [31:0] data);
        @(posedge clk);
        cfg_wr    <= 1'b1;
        cfg_addr  <= addr;
        cfg_wdata <= data;
        @(posedge clk);
        cfg_wr <= 1'b0;
        case (addr)
            udp_pkg::CFG_SRC_MAC_HI: src_mac_m[47:32] = data[15:0];
            udp_pkg::CFG_SRC_MAC_LO: src_mac_m[31:0]  = data;
            udp_pkg::CFG_DST_MAC_HI: dst_mac_m[47:32] = data[15:0];
            udp_pkg::CFG_DST_MAC_LO: dst_mac_m[31:0]  = data;
            udp_pkg::CFG_SRC_IP:     src_ip_m         = data;
            udp_pkg::CFG_DST_IP:     dst_ip_m         = data;
            udp_pkg::CFG_PORTS: begin
                sport_m = data[31:16];
                dport_m = data[15:0];
            end
            default: ;
        endcase
    endtask

    task automatic load_payload(input int n);
        logic [31:0] word;
        logic [7:0]  rnd;
        int          w;
        int          k;
        pl_bytes.delete();
        for (k = 0; k < n; k++) begin
            rnd = 8'($urandom_range(0, 255));
            pl_bytes.push_back(rnd);
        end
        for (w = 0; w < (n + 3) / 4; w++) begin
            for (k = 0; k < 4; k++) begin
                rnd = 8'($urandom_range(0, 255));   // tail bytes past n are junk
                word[8*(3-k) +: 8] = (4*w + k < n) ? pl_bytes[4*w + k] : rnd;
            end
            @(posedge clk);
            pl_wr    <= 1'b1;
            pl_wdata <= word;
        end
        @(posedge clk);
        pl_wr <= 1'b0;
        @(posedge clk);
        // full only once the buffer holds its whole depth
        check_value("pl_full", pl_full, ((n + 3) / 4 == FIFO_DEPTH) ? 32'd1 : 32'd0);
        if ((n + 3) / 4 == FIFO_DEPTH) begin
            pl_wr    <= 1'b1;               // lands on a full buffer and is lost
            pl_wdata <= 32'hdead_beef;
            @(posedge clk);
            pl_wr <= 1'b0;
        end
    endtask

    task automatic start_frame(input int n);
        byte_q_t frame;
        exp_id = exp_id + 16'd1;
        frame  = build_frame(n, exp_id, pl_bytes);
        foreach (frame[i])
            exp_q.push_back(frame[i]);
        len_q.push_back(frame.size());
        frames_sent++;
        @(posedge clk);
        tx_start    <= 1'b1;
        tx_byte_num <= 16'(n);
        @(posedge clk);
        tx_start <= 1'b0;
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        while (frames_done < frames_sent) begin
            @(posedge clk);
            cycles++;
            if (cycles > FRAME_CYCLES)
                fail_run($sformatf("no tx_done for frame %0d within %0d cycles",
                                   frames_sent, FRAME_CYCLES));
        end
        repeat (2) @(posedge clk);
    endtask

    task automatic run_frame(input int n);
        load_payload(n);
        start_frame(n);
        wait_done();
    endtask

    // ******************************
    // output compare
    // ******************************
    initial begin : compare_proc
        logic [7:0] exp_byte;
        int         rx_cnt;
        int         exp_len;
        logic       prev_en;
        logic       done_seen;
        rx_cnt    = 0;
        prev_en   = 1'b0;
        done_seen = 1'b0;
        forever begin
            @(posedge clk);
            if (rst_n) begin
                if (done_seen && !tx_start)
                    check_value("tx_busy", tx_busy, 32'd0);     // idle after done
                done_seen = 1'b0;
                if (gmii_tx_en || tx_done)
                    check_value("tx_busy", tx_busy, 32'd1);
                if (prev_en && !gmii_tx_en && !tx_done)
                    fail_run("gmii_tx_en dropped before the end of the frame");
                if (gmii_tx_en) begin
                    if (exp_q.size() == 0)
                        fail_run("gmii_tx_en is high while no frame is expected");
                    exp_byte = exp_q.pop_front();
                    check_value("gmii_txd", gmii_txd, exp_byte);
                    rx_cnt++;
                end
                if (tx_done) begin
                    if (len_q.size() == 0)
                        fail_run("tx_done pulsed with no frame outstanding");
                    exp_len = len_q.pop_front();
                    if (rx_cnt != exp_len)
                        fail_run($sformatf("frame was %0d bytes long, expected %0d",
                                           rx_cnt, exp_len));
                    if (!prev_en || gmii_tx_en)
                        fail_run("tx_done did not follow the last FCS byte");
                    rx_cnt    = 0;
                    done_seen = 1'b1;
                    frames_done++;
                end
                prev_en = gmii_tx_en;
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        fail_run($sformatf("watchdog expired after %0d cycles", WATCHDOG_CYCLES));
    end

    // ******************************
    // test sequence
    // ******************************
    initial begin : stimulus
        int n;
        int i;
        void'($urandom(23919));
        rst_n       = 1'b0;
        cfg_wr      = 1'b0;
        cfg_addr    = '0;
        cfg_wdata   = '0;
        pl_wr       = 1'b0;
        pl_wdata    = '0;
        tx_start    = 1'b0;
        tx_byte_num = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);

        run_frame(24);                  // reset config, id 1
        for (n = 1; n < 18; n++)
            run_frame(n);               // padded to 18
        run_frame(19);
        run_frame(63);
        for (i = 0; i < 10; i++) begin
            n = 18 + $urandom_range(0, 46);
            run_frame(n);
        end

        // new addresses between frames
        write_cfg(udp_pkg::CFG_SRC_MAC_HI, 32'h0000_0a0b);
        write_cfg(udp_pkg::CFG_SRC_MAC_LO, 32'h0c0d_0e0f);
        write_cfg(udp_pkg::CFG_DST_MAC_HI, 32'h0000_6a6b);
        write_cfg(udp_pkg::CFG_DST_MAC_LO, 32'h6c6d_6e6f);
        write_cfg(udp_pkg::CFG_SRC_IP, 32'h0a00_0001);
        write_cfg(udp_pkg::CFG_DST_IP, 32'h0a00_0002);
        write_cfg(udp_pkg::CFG_PORTS, {16'd5000, 16'd6000});
        write_cfg(3'd7, 32'hdead_beef);     // unmapped, mirror untouched
        run_frame(33);

        // write lands mid frame, only the next frame sees it
        load_payload(40);
        start_frame(40);
        repeat (30) @(posedge clk);
        write_cfg(udp_pkg::CFG_DST_IP, 32'hac10_0505);
        write_cfg(udp_pkg::CFG_PORTS, {16'd7001, 16'd7002});
        wait_done();
        run_frame(21);

        // start while busy must be dropped
        load_payload(50);
        start_frame(50);
        repeat (40) @(posedge clk);
        tx_start    <= 1'b1;
        tx_byte_num <= 16'd5;
        @(posedge clk);
        tx_start <= 1'b0;
        wait_done();
        repeat (40) @(posedge clk);

        if (frames_done != frames_sent || exp_q.size() != 0) begin
            $display("frames sent %0d, frames done %0d, %0d bytes never seen",
                     frames_sent, frames_done, exp_q.size());
            $display("SIMULATION FAILED");
            $fatal(1, "frame count mismatch");
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

//--- sim.f
logic/udp_pkg.sv
logic/udp_cfg_regs.sv
logic/payload_fifo.sv
logic/eth_crc32_d8.sv
logic/udp_tx.sv
logic/udp_tx_top.sv
verif/udp_tx_asserts.sv
verif/udp_tx_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the UDP transmit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module udp_tx_tb -f sim.f

./obj_dir/Vudp_tx_tb
